//--- eb_defines.svh
`ifndef EB_DEFINES_SVH
`define EB_DEFINES_SVH

// number of buffer entries
`define EB_DEPTH 16

// log2 of the depth
// pointers carry one extra wrap bit on top
`define EB_ADDR_W 4

// symbol payload width
`define EB_DATA_W 8

// fill level above which skips get deleted on the write side
`define EB_THRESHOLD 8

// payload shown on an inserted skip
`define EB_SKIP_CODE 8'h1C

`endif

//--- eb_pkg.sv
`default_nettype none

`include "eb_defines.svh"

package eb_pkg;

  // raw symbol payload
  typedef logic [`EB_DATA_W-1:0] eb_data_t;

  // pointer with wrap bit in binary or gray form
  typedef logic [`EB_ADDR_W:0] eb_ptr_t;

  // fill level from 0 up to full depth
  typedef logic [`EB_ADDR_W:0] eb_level_t;

  // one buffered symbol
  typedef struct packed {
    logic     skip;
    eb_data_t data;
  } eb_symbol_t;

  // read side states
  typedef enum logic [1:0] {
    RD_FILL,
    RD_RUN,
    RD_REPEAT
  } eb_rd_state_t;

endpackage

`default_nettype wire

//--- eb_storage.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module eb_storage (
  input  wire                     wr_clk,
  input  wire                     wr_en,
  input  wire [`EB_ADDR_W-1:0]    wr_addr,
  input  wire eb_pkg::eb_symbol_t wr_symbol,
  input  wire                     rd_clk,
  input  wire                     rd_en,
  input  wire [`EB_ADDR_W-1:0]    rd_addr,
  output eb_pkg::eb_symbol_t      rd_symbol
);

  // symbol array written in wr_clk domain
  eb_pkg::eb_symbol_t mem [`EB_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_symbol;
    end
  end

  // registered read with data valid one rd_clk after rd_en
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_symbol <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- eb_pointer_sync.sv
`timescale 1ns/1ns
`default_nettype none

module eb_pointer_sync (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire eb_pkg::eb_ptr_t gray_in,
  output eb_pkg::eb_ptr_t      gray_out
);

  // first stage may go metastable
  eb_pkg::eb_ptr_t meta_q;

  // only one gray bit moves per step, so a bus of flops is safe here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      meta_q   <= '0;
      gray_out <= '0;
    end else begin
      meta_q   <= gray_in;
      gray_out <= meta_q;
    end
  end

endmodule

`default_nettype wire

//--- threshold_monitor.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module threshold_monitor (
  input  wire eb_pkg::eb_ptr_t gray_read_pointer,
  input  wire eb_pkg::eb_ptr_t gray_write_pointer,
  output logic                 delete_req,
  output logic                 add_req
);

  eb_pkg::eb_ptr_t   bin_read_pointer;
  eb_pkg::eb_ptr_t   bin_write_pointer;
  eb_pkg::eb_level_t level;

  // gray to binary from the msb down
  function automatic eb_pkg::eb_ptr_t gray_to_bin(input eb_pkg::eb_ptr_t gray);
    eb_pkg::eb_ptr_t bin;
    bin[`EB_ADDR_W] = gray[`EB_ADDR_W];
    for (int i = `EB_ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  assign bin_read_pointer  = gray_to_bin(gray_read_pointer);
  assign bin_write_pointer = gray_to_bin(gray_write_pointer);

  // modular difference where the wrap bit keeps full and empty distinct
  assign level = bin_write_pointer - bin_read_pointer;

  // drop skips above threshold and insert them at or below
  assign delete_req = (level > `EB_THRESHOLD);
  assign add_req    = ~delete_req;

endmodule

`default_nettype wire

//--- eb_write_side.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module eb_write_side (
  input  wire                     wr_clk,
  input  wire                     rst_n,
  input  wire                     in_valid,
  input  wire eb_pkg::eb_symbol_t in_symbol,
  input  wire eb_pkg::eb_ptr_t    rd_ptr_gray_sync,
  input  wire                     delete_req,
  output logic                    wr_en,
  output logic [`EB_ADDR_W-1:0]   wr_addr,
  output eb_pkg::eb_symbol_t      wr_symbol,
  output eb_pkg::eb_ptr_t         wr_ptr_gray,
  output logic                    overflow
);

  eb_pkg::eb_ptr_t wr_ptr_bin;
  eb_pkg::eb_ptr_t wr_ptr_bin_next;
  eb_pkg::eb_ptr_t rd_ptr_gray_full;
  logic            store_due;
  logic            full;

  // every valid symbol is stored except a skip while the level is high
  assign store_due = in_valid && !(in_symbol.skip && delete_req);

  // full in gray terms means top two bits inverted and the rest equal
  assign rd_ptr_gray_full = {~rd_ptr_gray_sync[`EB_ADDR_W:`EB_ADDR_W-1],
                             rd_ptr_gray_sync[`EB_ADDR_W-2:0]};
  assign full = (wr_ptr_gray == rd_ptr_gray_full);

  // never write over unread data and lose the symbol instead
  assign wr_en     = store_due && !full;
  assign wr_addr   = wr_ptr_bin[`EB_ADDR_W-1:0];
  assign wr_symbol = in_symbol;

  assign wr_ptr_bin_next = wr_ptr_bin + 1'b1;

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      wr_ptr_bin  <= '0;
      wr_ptr_gray <= '0;
      overflow    <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_bin  <= wr_ptr_bin_next;
        // registered gray copy feeds the read domain sync
        wr_ptr_gray <= wr_ptr_bin_next ^ (wr_ptr_bin_next >> 1);
      end
      // sticky until reset
      if (store_due && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- eb_read_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module eb_read_ctrl (
  input  wire                     rd_clk,
  input  wire                     rst_n,
  input  wire eb_pkg::eb_ptr_t    wr_ptr_gray_sync,
  input  wire                     add_req,
  input  wire eb_pkg::eb_symbol_t rd_symbol,
  output logic                    rd_en,
  output logic [`EB_ADDR_W-1:0]   rd_addr,
  output eb_pkg::eb_ptr_t         rd_ptr_gray,
  output logic                    out_valid,
  output eb_pkg::eb_symbol_t      out_symbol,
  output logic                    underflow
);

  eb_pkg::eb_rd_state_t state;
  eb_pkg::eb_rd_state_t state_next;
  eb_pkg::eb_ptr_t      rd_ptr_bin;
  eb_pkg::eb_ptr_t      rd_ptr_bin_next;
  logic                 rd_vld_q;
  logic                 empty;
  logic                 repeat_hit;
  logic                 read_due;

  // empty against the synced write pointer is conservative
  assign empty = (rd_ptr_gray == wr_ptr_gray_sync);

  // hold the pointer one cycle after a skip is delivered at low level
  assign repeat_hit = (state == eb_pkg::RD_RUN) && rd_vld_q && rd_symbol.skip && add_req;

  always_comb begin
    state_next = state;
    read_due   = 1'b0;
    case (state)
      eb_pkg::RD_FILL: begin
        // add_req low means level above threshold
        if (!add_req) begin
          state_next = eb_pkg::RD_RUN;
          read_due   = 1'b1;
        end
      end
      eb_pkg::RD_RUN: begin
        if (repeat_hit) begin
          state_next = eb_pkg::RD_REPEAT;
        end else begin
          read_due = 1'b1;
        end
      end
      eb_pkg::RD_REPEAT: begin
        // resume reading while the inserted skip goes out
        state_next = eb_pkg::RD_RUN;
        read_due   = 1'b1;
      end
      default: begin
        state_next = eb_pkg::RD_FILL;
      end
    endcase
  end

  assign rd_en           = read_due && !empty;
  assign rd_addr         = rd_ptr_bin[`EB_ADDR_W-1:0];
  assign rd_ptr_bin_next = rd_ptr_bin + 1'b1;

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      state       <= eb_pkg::RD_FILL;
      rd_ptr_bin  <= '0;
      rd_ptr_gray <= '0;
      rd_vld_q    <= 1'b0;
      underflow   <= 1'b0;
    end else begin
      state    <= state_next;
      // storage data lands one cycle after rd_en
      rd_vld_q <= rd_en;
      if (rd_en) begin
        rd_ptr_bin  <= rd_ptr_bin_next;
        rd_ptr_gray <= rd_ptr_bin_next ^ (rd_ptr_bin_next >> 1);
      end
      // sticky flag for a read wanted while running with nothing there
      if (read_due && empty && (state != eb_pkg::RD_FILL)) begin
        underflow <= 1'b1;
      end
    end
  end

  // inserted skip fills the slot left by the held pointer
  assign out_valid = rd_vld_q || (state == eb_pkg::RD_REPEAT);

  always_comb begin
    out_symbol = rd_symbol;
    if (state == eb_pkg::RD_REPEAT) begin
      out_symbol.skip = 1'b1;
      out_symbol.data = `EB_SKIP_CODE;
    end
  end

endmodule

`default_nettype wire

//--- elastic_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module elastic_buffer (
  input  wire                     wr_clk,
  input  wire                     rd_clk,
  input  wire                     rst_n,
  input  wire                     in_valid,
  input  wire eb_pkg::eb_symbol_t in_symbol,
  output logic                    out_valid,
  output eb_pkg::eb_symbol_t      out_symbol,
  output logic                    overflow,
  output logic                    underflow
);

  // storage ports
  logic                  wr_en;
  logic [`EB_ADDR_W-1:0] wr_addr;
  eb_pkg::eb_symbol_t    wr_symbol;
  logic                  rd_en;
  logic [`EB_ADDR_W-1:0] rd_addr;
  eb_pkg::eb_symbol_t    rd_symbol;

  // local and crossed pointers
  eb_pkg::eb_ptr_t wr_ptr_gray;
  eb_pkg::eb_ptr_t rd_ptr_gray;
  eb_pkg::eb_ptr_t wr_ptr_gray_sync;
  eb_pkg::eb_ptr_t rd_ptr_gray_sync;

  // one request used per domain
  logic delete_req;
  logic add_req;

  eb_storage u_storage (
    .wr_clk    (wr_clk),
    .wr_en     (wr_en),
    .wr_addr   (wr_addr),
    .wr_symbol (wr_symbol),
    .rd_clk    (rd_clk),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_symbol (rd_symbol)
  );

  // read pointer into wr_clk
  eb_pointer_sync u_rd_ptr_sync (
    .clk      (wr_clk),
    .rst_n    (rst_n),
    .gray_in  (rd_ptr_gray),
    .gray_out (rd_ptr_gray_sync)
  );

  // write pointer into rd_clk
  eb_pointer_sync u_wr_ptr_sync (
    .clk      (rd_clk),
    .rst_n    (rst_n),
    .gray_in  (wr_ptr_gray),
    .gray_out (wr_ptr_gray_sync)
  );

  // write domain copy drives deletion
  threshold_monitor u_wr_monitor (
    .gray_read_pointer  (rd_ptr_gray_sync),
    .gray_write_pointer (wr_ptr_gray),
    .delete_req         (delete_req),
    .add_req            ()
  );

  // read domain copy drives insertion
  threshold_monitor u_rd_monitor (
    .gray_read_pointer  (rd_ptr_gray),
    .gray_write_pointer (wr_ptr_gray_sync),
    .delete_req         (),
    .add_req            (add_req)
  );

  eb_write_side u_write_side (
    .wr_clk           (wr_clk),
    .rst_n            (rst_n),
    .in_valid         (in_valid),
    .in_symbol        (in_symbol),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .delete_req       (delete_req),
    .wr_en            (wr_en),
    .wr_addr          (wr_addr),
    .wr_symbol        (wr_symbol),
    .wr_ptr_gray      (wr_ptr_gray),
    .overflow         (overflow)
  );

  eb_read_ctrl u_read_ctrl (
    .rd_clk           (rd_clk),
    .rst_n            (rst_n),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .add_req          (add_req),
    .rd_symbol        (rd_symbol),
    .rd_en            (rd_en),
    .rd_addr          (rd_addr),
    .rd_ptr_gray      (rd_ptr_gray),
    .out_valid        (out_valid),
    .out_symbol       (out_symbol),
    .underflow        (underflow)
  );

endmodule

`default_nettype wire

//--- tb_elastic_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "eb_defines.svh"

module tb_elastic_buffer;

  localparam int WR_HALF = 10;
  localparam int PHASES = 37;
  localparam int DRAIN_LIMIT = 400;
  localparam int OVERFLOW_LIMIT = 600;
  // link skips carry their own payload so inserted ones stand out
  localparam eb_pkg::eb_data_t LINK_SKIP = ~`EB_SKIP_CODE;

  logic               wr_clk;
  logic               rd_clk;
  logic               rst_n;
  logic               in_valid;
  eb_pkg::eb_symbol_t in_symbol;
  logic               out_valid;
  eb_pkg::eb_symbol_t out_symbol;
  logic               overflow;
  logic               underflow;

  // each phase is four words of half-period, first payload, count and spacing
  logic [15:0]        stim [PHASES*4];
  eb_pkg::eb_data_t   exp_q [$];
  eb_pkg::eb_symbol_t exp_sym;
  eb_pkg::eb_symbol_t link_skip_sym;
  int                 rd_half = 11;
  int                 sent_total;
  int                 inserted;
  int                 check_count;
  int                 error_count;
  int                 phase_count;
  logic               check_en;
  logic               aborted;
  logic               done;

  elastic_buffer dut (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_symbol  (in_symbol),
    .out_valid  (out_valid),
    .out_symbol (out_symbol),
    .overflow   (overflow),
    .underflow  (underflow)
  );

  initial begin
    wr_clk = 1'b0;
    forever #(WR_HALF) wr_clk = ~wr_clk;
  end

  // read clock follows the current phase and starts offset from wr_clk
  initial begin
    rd_clk = 1'b0;
    #3;
    forever #(rd_half) rd_clk = ~rd_clk;
  end

  task automatic check_symbol(input eb_pkg::eb_symbol_t got, input eb_pkg::eb_symbol_t exp,
                              input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s, got skip %0b data %02h, expected skip %0b data %02h",
               $time, what, got.skip, got.data, exp.skip, exp.data);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic drive_symbol(input logic skip, input eb_pkg::eb_data_t data);
    @(negedge wr_clk);
    // with at most threshold symbols stored the reader must still be idle
    if (sent_total <= `EB_THRESHOLD) begin
      check_flag(out_valid, 1'b0, "out_valid during initial fill");
      check_flag(overflow, 1'b0, "overflow during initial fill");
      check_flag(underflow, 1'b0, "underflow during initial fill");
    end
    in_valid = 1'b1;
    in_symbol.skip = skip;
    in_symbol.data = data;
    sent_total++;
  endtask

  // output monitor sampled mid read cycle
  always @(negedge rd_clk) begin
    if (out_valid === 1'b1 && check_en) begin
      if (out_symbol.skip && out_symbol.data == `EB_SKIP_CODE) begin
        inserted++;
      end else if (out_symbol.skip) begin
        check_symbol(out_symbol, link_skip_sym, "link skip payload");
      end else if (exp_q.size() == 0) begin
        error_count++;
        $display("payload %02h came out at %0t ns with nothing outstanding",
                 out_symbol.data, $time);
      end else begin
        exp_sym.skip = 1'b0;
        exp_sym.data = exp_q.pop_front();
        check_symbol(out_symbol, exp_sym, "payload order");
      end
    end
  end

  task automatic run_phase(input int p);
    int               half;
    int               count;
    int               spacing;
    int               waited;
    eb_pkg::eb_data_t data;
    half    = stim[4*p];
    data    = stim[4*p+1][`EB_DATA_W-1:0];
    count   = stim[4*p+2];
    spacing = stim[4*p+3];
    rd_half = half;
    inserted = 0;
    for (int i = 1; i <= count; i++) begin
      if (i % spacing == 0) begin
        drive_symbol(1'b1, LINK_SKIP);
      end else begin
        drive_symbol(1'b0, data);
        exp_q.push_back(data);
        data++;
      end
    end
    // idle link sends skips while the buffer drains
    waited = 0;
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      drive_symbol(1'b1, LINK_SKIP);
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("phase %0d timed out with %0d payloads never delivered", p, exp_q.size());
      aborted = 1'b1;
    end else begin
      check_flag(overflow, 1'b0, "overflow");
      // underflow belongs to rd_clk and is read between its edges
      @(negedge rd_clk);
      check_flag(underflow, 1'b0, "underflow");
      if (half < WR_HALF) begin
        check_flag(inserted != 0, 1'b1, "skip insertion with faster reader");
      end
    end
    $display("phase %0d: rd half-period %0d ns, %0d symbols, %0d inserted skips, %0d errors",
             p, half, count, inserted, error_count);
  endtask

  task automatic run_overflow_phase(input int p);
    int               count;
    int               waited;
    eb_pkg::eb_data_t data;
    check_en = 1'b0;
    rd_half  = stim[4*p];
    data     = stim[4*p+1][`EB_DATA_W-1:0];
    count    = stim[4*p+2];
    for (int i = 0; i < count; i++) begin
      drive_symbol(1'b0, data);
      data++;
    end
    // with no skips to drop the faster writer must fill the buffer
    waited = 0;
    while (overflow !== 1'b1 && waited < OVERFLOW_LIMIT) begin
      drive_symbol(1'b0, data);
      data++;
      waited++;
    end
    check_flag(overflow, 1'b1, "overflow after stream without skips");
    repeat (32) drive_symbol(1'b1, LINK_SKIP);
    check_flag(overflow, 1'b1, "overflow held after link idles");
    $display("phase %0d: overflow run, %0d symbols, %0d errors", p, count + waited, error_count);
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid = 1'b0;
    in_symbol = '0;
    check_en = 1'b1;
    aborted = 1'b0;
    done = 1'b0;
    sent_total = 0;
    inserted = 0;
    check_count = 0;
    error_count = 0;
    phase_count = 0;
    link_skip_sym.skip = 1'b1;
    link_skip_sym.data = LINK_SKIP;
    $readmemh("eb_stimulus.txt", stim);
    if ($isunknown(stim[0]) || stim[0] == 0) begin
      $display("stimulus file eb_stimulus.txt is missing or empty");
      aborted = 1'b1;
    end else begin
      rd_half = stim[0];
    end
    repeat (16) @(posedge wr_clk);
    @(negedge wr_clk);
    rst_n = 1'b1;
    check_flag(out_valid, 1'b0, "out_valid after reset");
    check_flag(overflow, 1'b0, "overflow after reset");
    check_flag(underflow, 1'b0, "underflow after reset");
    while (!done && !aborted && phase_count < PHASES) begin
      // zero spacing marks the closing overflow phase
      if (stim[4*phase_count+3] == 0) begin
        run_overflow_phase(phase_count);
        done = 1'b1;
      end else begin
        run_phase(phase_count);
      end
      phase_count++;
    end
    $display("%0d phases, %0d checks, %0d errors", phase_count, check_count, error_count);
    if (error_count == 0 && !aborted) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- eb_stimulus.txt
// columns: rd_clk half-period in ns, first payload, symbol count, skip spacing
// all hex; half-period 0b is the slower reader, 09 the faster one
// spacing 0 means no skips and closes the run with an overflow
000b 0000 0040 0004
0009 0040 0040 0004
000b 0080 0030 0005
000b 00a0 0028 0003
0009 00c0 0050 0005
0009 0010 0020 0004
000b 0030 0048 0004
0009 0070 0038 0003
000b 00f0 0030 0005
0009 0020 0040 0004
000b 0060 0020 0003
0009 0090 0048 0005
000b 00d0 0038 0004
0009 0005 0030 0003
000b 0045 0040 0005
0009 0085 0028 0004
000b 00b5 0050 0004
0009 00e5 0020 0005
0009 0011 0038 0004
000b 0041 0030 0003
0009 0071 0040 0005
000b 00a1 0028 0004
0009 00d1 0048 0003
000b 0001 0038 0005
0009 0031 0030 0004
000b 0061 0040 0004
0009 0091 0020 0003
000b 00c1 0048 0005
000b 00f1 0030 0004
0009 0021 0038 0004
000b 0051 0028 0003
0009 0081 0050 0005
000b 00b1 0020 0004
0009 00e1 0040 0003
000b 0011 0030 0005
0009 0041 0038 0004
000b 0077 00a0 0000

//--- build.f
+incdir+.
eb_pkg.sv
eb_storage.sv
eb_pointer_sync.sv
threshold_monitor.sv
eb_write_side.sv
eb_read_ctrl.sv
elastic_buffer.sv
tb_elastic_buffer.sv

//--- Bender.yml
package:
  name: elastic_buffer

sources:
  - include_dirs:
      - .
    files:
      - eb_pkg.sv
      - eb_storage.sv
      - eb_pointer_sync.sv
      - threshold_monitor.sv
      - eb_write_side.sv
      - eb_read_ctrl.sv
      - elastic_buffer.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_elastic_buffer.sv
